// File: rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    // Raw RV64 instruction word, fixed 32 bits
    typedef logic [31:0] instr_t;

    // Major opcodes of the supported instructions
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // funct3 values
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SRL     = 3'b101;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_LD      = 3'b011;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BGE     = 3'b101;

    // funct7 values for R-type
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    // Field extraction
    function automatic logic [6:0] opcode_of(instr_t word);
        return word[6:0];
    endfunction

    function automatic logic [2:0] funct3_of(instr_t word);
        return word[14:12];
    endfunction

    function automatic logic [6:0] funct7_of(instr_t word);
        return word[31:25];
    endfunction

endpackage

`default_nettype wire

// File: cpu_ctrl_pkg.sv
`default_nettype none

package cpu_ctrl_pkg;

    // Sequencer phases, every legal instruction walks FETCH..COMPLETE
    typedef enum logic [2:0] {
        PREPARE  = 3'd0,
        FETCH    = 3'd1,
        LATCH    = 3'd2,
        EXEC     = 3'd3,
        COMPLETE = 3'd4,
        TRAP     = 3'd7
    } ctrl_state_t;

    // Decoded instruction class, held through EXEC and COMPLETE
    typedef enum logic [2:0] {
        CLS_ALU_REG = 3'd0,
        CLS_ALU_IMM = 3'd1,
        CLS_LUI     = 3'd2,
        CLS_LOAD    = 3'd3,
        CLS_BEQ     = 3'd4,
        CLS_BGE     = 3'd5,
        CLS_JAL     = 3'd6,
        CLS_ILLEGAL = 3'd7
    } instr_class_t;

    // ALU operation codes as the datapath ALU expects them
    typedef enum logic [7:0] {
        ALU_ADD  = 8'd0,
        ALU_ADDI = 8'd1,
        ALU_SUB  = 8'd2,
        ALU_SLL  = 8'd5,
        ALU_SRL  = 8'd6,
        ALU_AND  = 8'd7,
        ALU_OR   = 8'd8,
        ALU_XOR  = 8'd10,
        ALU_LUI  = 8'd11
    } alu_op_t;

    // Second ALU operand source
    typedef enum logic [1:0] {
        OP2_REG   = 2'b00,
        OP2_UPPER = 2'b01,
        OP2_IMM   = 2'b10
    } op2_sel_t;

    // Register file write-back source
    typedef enum logic [1:0] {
        REG_SRC_NONE = 2'b00,
        REG_SRC_RAM  = 2'b01,
        REG_SRC_ALU  = 2'b10,
        REG_SRC_PC   = 2'b11
    } reg_src_t;

    // Next PC source, 10 is unused
    typedef enum logic [1:0] {
        PC_SRC_BEQ = 2'b00,
        PC_SRC_JAL = 2'b01,
        PC_SRC_BGE = 2'b11
    } pc_src_t;

endpackage

`default_nettype wire

// File: instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder
    import rv_isa_pkg::*;
    import cpu_ctrl_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         latch,
    input  instr_t       instr,
    output logic         illegal,
    output instr_class_t cls,
    output alu_op_t      alu_code
);

    logic [6:0]   opcode;
    logic [2:0]   funct3;
    logic [6:0]   funct7;
    logic         r_base;
    instr_class_t next_cls;
    alu_op_t      next_alu;

    assign opcode = opcode_of(instr);
    assign funct3 = funct3_of(instr);
    assign funct7 = funct7_of(instr);

    // Plain R-type with zero funct7
    assign r_base = (opcode == OPC_OP) && (funct7 == F7_BASE);

    // Priority chain where the first match wins
    always_comb begin
        next_cls = CLS_ILLEGAL;
        next_alu = ALU_ADD;
        if (opcode == OPC_OP_IMM && funct3 == F3_ADD_SUB) begin
            next_cls = CLS_ALU_IMM;
            next_alu = ALU_ADDI;
        end else if (r_base && funct3 == F3_ADD_SUB) begin
            next_cls = CLS_ALU_REG;
            next_alu = ALU_ADD;
        end else if (opcode == OPC_OP && funct7 == F7_SUB && funct3 == F3_ADD_SUB) begin
            next_cls = CLS_ALU_REG;
            next_alu = ALU_SUB;
        end else if (r_base && funct3 == F3_SLL) begin
            next_cls = CLS_ALU_REG;
            next_alu = ALU_SLL;
        end else if (r_base && funct3 == F3_SRL) begin
            next_cls = CLS_ALU_REG;
            next_alu = ALU_SRL;
        end else if (r_base && funct3 == F3_OR) begin
            next_cls = CLS_ALU_REG;
            next_alu = ALU_OR;
        end else if (r_base && funct3 == F3_AND) begin
            next_cls = CLS_ALU_REG;
            next_alu = ALU_AND;
        end else if (r_base && funct3 == F3_XOR) begin
            next_cls = CLS_ALU_REG;
            next_alu = ALU_XOR;
        end else if (opcode == OPC_LOAD && funct3 == F3_LD) begin
            next_cls = CLS_LOAD;
        end else if (opcode == OPC_BRANCH && funct3 == F3_BEQ) begin
            next_cls = CLS_BEQ;
        end else if (opcode == OPC_BRANCH && funct3 == F3_BGE) begin
            next_cls = CLS_BGE;
        end else if (opcode == OPC_JAL) begin
            next_cls = CLS_JAL;
        end else if (opcode == OPC_OP_IMM && funct3 == F3_XOR) begin
            next_cls = CLS_ALU_IMM;
            next_alu = ALU_XOR;
        end else if (opcode == OPC_LUI) begin
            next_cls = CLS_LUI;
            next_alu = ALU_LUI;
        end
    end

    // Only meaningful while latch is high
    assign illegal = (next_cls == CLS_ILLEGAL);

    // Class and ALU code stay put until the next LATCH
    always_ff @(posedge clk) begin
        if (reset) begin
            cls      <= CLS_ILLEGAL;
            alu_code <= ALU_ADD;
        end else if (latch) begin
            cls      <= next_cls;
            alu_code <= next_alu;
        end
    end

    // Instruction memory must present a known word during LATCH
    a_instr_known: assert property (
        @(posedge clk) disable iff (reset)
        latch |-> !$isunknown(instr)
    ) else $error("instruction word unknown while latching");

endmodule

`default_nettype wire

// File: ctrl_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module ctrl_sequencer
    import cpu_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        illegal,
    output ctrl_state_t state,
    output logic        latch
);

    ctrl_state_t next_state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= PREPARE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        case (state)
            PREPARE:  next_state = FETCH;
            FETCH:    next_state = LATCH;
            // Unknown word parks the unit until reset
            LATCH:    next_state = illegal ? TRAP : EXEC;
            EXEC:     next_state = COMPLETE;
            COMPLETE: next_state = FETCH;
            TRAP:     next_state = TRAP;
            default:  next_state = TRAP;
        endcase
    end

    // Decoder capture strobe
    assign latch = (state == LATCH);

    a_state_legal: assert property (
        @(posedge clk) disable iff (reset)
        state inside {PREPARE, FETCH, LATCH, EXEC, COMPLETE, TRAP}
    ) else $error("sequencer state out of range");

    a_trap_sticky: assert property (
        @(posedge clk) disable iff (reset)
        (state == TRAP) |=> (state == TRAP)
    ) else $error("TRAP left without reset");

endmodule

`default_nettype wire

// File: ctrl_signal_gen.sv
`timescale 1ns/1ps
`default_nettype none

module ctrl_signal_gen
    import cpu_ctrl_pkg::*;
(
    input  ctrl_state_t  state,
    input  instr_class_t cls,
    input  alu_op_t      alu_code,
    output logic         ram_cs,
    output logic         ram_we,
    output logic         ram_oe,
    output logic         pc_en,
    output pc_src_t      pc_in_dir,
    output logic         pc_sign,
    output logic         ir_en,
    output logic         reg_en,
    output logic         reg_we,
    output reg_src_t     reg_in_dir,
    output logic         alu_en,
    output alu_op_t      alu_op,
    output op2_sel_t     op2_dir
);

    // Store path is gone, RAM is never written
    assign ram_we = 1'b0;

    always_comb begin
        ram_cs     = 1'b0;
        ram_oe     = 1'b0;
        pc_en      = 1'b0;
        pc_in_dir  = PC_SRC_BEQ;
        pc_sign    = 1'b0;
        ir_en      = 1'b0;
        reg_en     = 1'b0;
        reg_we     = 1'b0;
        reg_in_dir = REG_SRC_NONE;
        alu_en     = 1'b0;
        alu_op     = ALU_ADD;
        op2_dir    = OP2_REG;

        case (state)
            FETCH: begin
                // Read instruction at PC and step PC
                ram_cs = 1'b1;
                ram_oe = 1'b1;
                pc_en  = 1'b1;
            end
            LATCH: begin
                ir_en = 1'b1;
            end
            EXEC: begin
                case (cls)
                    CLS_ALU_REG, CLS_ALU_IMM, CLS_LUI: begin
                        alu_en = 1'b1;
                        alu_op = alu_code;
                        if (cls == CLS_ALU_IMM) begin
                            op2_dir = OP2_IMM;
                        end else if (cls == CLS_LUI) begin
                            op2_dir = OP2_UPPER;
                        end
                    end
                    CLS_LOAD: begin
                        ram_cs = 1'b1;
                        ram_oe = 1'b1;
                    end
                    // Compare by subtraction
                    CLS_BEQ, CLS_BGE: begin
                        alu_en = 1'b1;
                        alu_op = ALU_SUB;
                    end
                    // Link address goes to rd
                    CLS_JAL: begin
                        reg_en     = 1'b1;
                        reg_we     = 1'b1;
                        reg_in_dir = REG_SRC_PC;
                    end
                    default: ;
                endcase
            end
            COMPLETE: begin
                case (cls)
                    CLS_ALU_REG, CLS_ALU_IMM, CLS_LUI: begin
                        reg_en     = 1'b1;
                        reg_we     = 1'b1;
                        reg_in_dir = REG_SRC_ALU;
                    end
                    CLS_LOAD: begin
                        reg_en     = 1'b1;
                        reg_we     = 1'b1;
                        reg_in_dir = REG_SRC_RAM;
                    end
                    CLS_BEQ, CLS_BGE, CLS_JAL: begin
                        pc_en   = 1'b1;
                        pc_sign = 1'b1;
                        if (cls == CLS_BGE) begin
                            pc_in_dir = PC_SRC_BGE;
                        end else if (cls == CLS_JAL) begin
                            pc_in_dir = PC_SRC_JAL;
                        end
                    end
                    default: ;
                endcase
            end
            // PREPARE and TRAP drive nothing
            default: ;
        endcase
    end

    // ALU and RAM share no cycle, and a write needs the file enabled
    always_comb begin
        a_no_bus_clash: assert (!(alu_en && ram_cs))
            else $error("alu_en and ram_cs high together");
        a_we_needs_en: assert (!(reg_we && !reg_en))
            else $error("reg_we without reg_en");
    end

endmodule

`default_nettype wire

// File: cpu_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_ctrl
    import rv_isa_pkg::*;
    import cpu_ctrl_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  instr_t   instr,
    output logic     ram_cs,
    output logic     ram_we,
    output logic     ram_oe,
    output logic     pc_en,
    output pc_src_t  pc_in_dir,
    output logic     pc_sign,
    output logic     ir_en,
    output logic     reg_en,
    output logic     reg_we,
    output reg_src_t reg_in_dir,
    output logic     alu_en,
    output alu_op_t  alu_op,
    output op2_sel_t op2_dir
);

    ctrl_state_t  state;
    logic         latch;
    logic         illegal;
    instr_class_t cls;
    alu_op_t      alu_code;

    instr_decoder u_decoder (
        .clk      (clk),
        .reset    (reset),
        .latch    (latch),
        .instr    (instr),
        .illegal  (illegal),
        .cls      (cls),
        .alu_code (alu_code)
    );

    ctrl_sequencer u_sequencer (
        .clk     (clk),
        .reset   (reset),
        .illegal (illegal),
        .state   (state),
        .latch   (latch)
    );

    ctrl_signal_gen u_signal_gen (
        .state      (state),
        .cls        (cls),
        .alu_code   (alu_code),
        .ram_cs     (ram_cs),
        .ram_we     (ram_we),
        .ram_oe     (ram_oe),
        .pc_en      (pc_en),
        .pc_in_dir  (pc_in_dir),
        .pc_sign    (pc_sign),
        .ir_en      (ir_en),
        .reg_en     (reg_en),
        .reg_we     (reg_we),
        .reg_in_dir (reg_in_dir),
        .alu_en     (alu_en),
        .alu_op     (alu_op),
        .op2_dir    (op2_dir)
    );

endmodule

`default_nettype wire

// File: tb_cpu_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_ctrl
    import rv_isa_pkg::*;
    import cpu_ctrl_pkg::*;
;

    localparam int FETCH_TIMEOUT = 8;
    localparam int TRAP_WINDOW   = 20;

    // Expected value of every control output in one cycle
    typedef struct packed {
        logic     ram_cs;
        logic     ram_we;
        logic     ram_oe;
        logic     pc_en;
        pc_src_t  pc_in_dir;
        logic     pc_sign;
        logic     ir_en;
        logic     reg_en;
        logic     reg_we;
        reg_src_t reg_in_dir;
        logic     alu_en;
        alu_op_t  alu_op;
        op2_sel_t op2_dir;
    } ctrl_word_t;

    logic     clk;
    logic     reset;
    instr_t   instr;
    logic     ram_cs;
    logic     ram_we;
    logic     ram_oe;
    logic     pc_en;
    pc_src_t  pc_in_dir;
    logic     pc_sign;
    logic     ir_en;
    logic     reg_en;
    logic     reg_we;
    reg_src_t reg_in_dir;
    logic     alu_en;
    alu_op_t  alu_op;
    op2_sel_t op2_dir;

    integer   seed;
    int       value_errors;
    int       timing_errors;
    int       idx;
    instr_t   rnd;
    instr_t   word;

    cpu_ctrl uut (
        .clk        (clk),
        .reset      (reset),
        .instr      (instr),
        .ram_cs     (ram_cs),
        .ram_we     (ram_we),
        .ram_oe     (ram_oe),
        .pc_en      (pc_en),
        .pc_in_dir  (pc_in_dir),
        .pc_sign    (pc_sign),
        .ir_en      (ir_en),
        .reg_en     (reg_en),
        .reg_we     (reg_we),
        .reg_in_dir (reg_in_dir),
        .alu_en     (alu_en),
        .alu_op     (alu_op),
        .op2_dir    (op2_dir)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Control word a phase should produce for a given instruction word
    function automatic ctrl_word_t expected_ctrl(input ctrl_state_t phase, input instr_t w_in);
        ctrl_word_t w;
        logic [6:0] opc;
        logic [2:0] f3;
        logic [6:0] f7;
        logic       is_alu;
        logic       is_load;
        logic       is_branch;
        logic       is_jal;
        alu_op_t    op;
        op2_sel_t   src2;
        pc_src_t    target;
        opc       = w_in[6:0];
        f3        = w_in[14:12];
        f7        = w_in[31:25];
        w         = '0;
        is_alu    = 1'b0;
        is_load   = 1'b0;
        is_branch = 1'b0;
        is_jal    = 1'b0;
        op        = ALU_ADD;
        src2      = OP2_REG;
        target    = PC_SRC_BEQ;
        case (opc)
            OPC_OP: begin
                if (f7 == F7_SUB && f3 == F3_ADD_SUB) begin
                    is_alu = 1'b1;
                    op     = ALU_SUB;
                end else if (f7 == F7_BASE) begin
                    is_alu = 1'b1;
                    case (f3)
                        F3_ADD_SUB: op = ALU_ADD;
                        F3_SLL:     op = ALU_SLL;
                        F3_SRL:     op = ALU_SRL;
                        F3_XOR:     op = ALU_XOR;
                        F3_OR:      op = ALU_OR;
                        F3_AND:     op = ALU_AND;
                        default:    is_alu = 1'b0;
                    endcase
                end
            end
            OPC_OP_IMM: begin
                src2   = OP2_IMM;
                is_alu = (f3 == F3_ADD_SUB) || (f3 == F3_XOR);
                op     = (f3 == F3_XOR) ? ALU_XOR : ALU_ADDI;
            end
            OPC_LUI: begin
                is_alu = 1'b1;
                op     = ALU_LUI;
                src2   = OP2_UPPER;
            end
            OPC_LOAD:   is_load = (f3 == F3_LD);
            OPC_BRANCH: begin
                is_branch = (f3 == F3_BEQ) || (f3 == F3_BGE);
                target    = (f3 == F3_BGE) ? PC_SRC_BGE : PC_SRC_BEQ;
            end
            OPC_JAL:    is_jal = 1'b1;
            default: ;
        endcase
        case (phase)
            FETCH: begin
                w.ram_cs = 1'b1;
                w.ram_oe = 1'b1;
                w.pc_en  = 1'b1;
            end
            LATCH: w.ir_en = 1'b1;
            EXEC: begin
                if (is_alu) begin
                    w.alu_en  = 1'b1;
                    w.alu_op  = op;
                    w.op2_dir = src2;
                end else if (is_load) begin
                    w.ram_cs = 1'b1;
                    w.ram_oe = 1'b1;
                end else if (is_branch) begin
                    w.alu_en = 1'b1;
                    w.alu_op = ALU_SUB;
                end else if (is_jal) begin
                    w.reg_en     = 1'b1;
                    w.reg_we     = 1'b1;
                    w.reg_in_dir = REG_SRC_PC;
                end
            end
            COMPLETE: begin
                if (is_alu || is_load) begin
                    w.reg_en     = 1'b1;
                    w.reg_we     = 1'b1;
                    w.reg_in_dir = is_load ? REG_SRC_RAM : REG_SRC_ALU;
                end else if (is_branch || is_jal) begin
                    w.pc_en     = 1'b1;
                    w.pc_sign   = 1'b1;
                    w.pc_in_dir = is_jal ? PC_SRC_JAL : target;
                end
            end
            // PREPARE and TRAP are silent
            default: ;
        endcase
        return w;
    endfunction

    // Kept instruction forms, register fields and immediates from rnd
    function automatic instr_t kept_form(input int sel, input instr_t rnd_in);
        case (sel)
            0:  return {F7_BASE, rnd_in[24:15], F3_ADD_SUB, rnd_in[11:7], OPC_OP};
            1:  return {F7_SUB, rnd_in[24:15], F3_ADD_SUB, rnd_in[11:7], OPC_OP};
            2:  return {F7_BASE, rnd_in[24:15], F3_SLL, rnd_in[11:7], OPC_OP};
            3:  return {F7_BASE, rnd_in[24:15], F3_SRL, rnd_in[11:7], OPC_OP};
            4:  return {F7_BASE, rnd_in[24:15], F3_AND, rnd_in[11:7], OPC_OP};
            5:  return {F7_BASE, rnd_in[24:15], F3_OR, rnd_in[11:7], OPC_OP};
            6:  return {F7_BASE, rnd_in[24:15], F3_XOR, rnd_in[11:7], OPC_OP};
            7:  return {rnd_in[31:15], F3_ADD_SUB, rnd_in[11:7], OPC_OP_IMM};
            8:  return {rnd_in[31:15], F3_XOR, rnd_in[11:7], OPC_OP_IMM};
            9:  return {rnd_in[31:7], OPC_LUI};
            10: return {rnd_in[31:15], F3_LD, rnd_in[11:7], OPC_LOAD};
            11: return {rnd_in[31:15], F3_BEQ, rnd_in[11:7], OPC_BRANCH};
            12: return {rnd_in[31:15], F3_BGE, rnd_in[11:7], OPC_BRANCH};
            default: return {rnd_in[31:7], OPC_JAL};
        endcase
    endfunction

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h expected %h at %0t", name, got, exp, $time);
            value_errors++;
        end
    endtask

    task automatic check_alu_op(input string tag, input alu_op_t got, input alu_op_t exp);
        if (got !== exp) begin
            $display("FAILED %s alu_op: got %h expected %h at %0t", tag, got, exp, $time);
            value_errors++;
        end
    endtask

    task automatic check_op2(input string tag, input op2_sel_t got, input op2_sel_t exp);
        if (got !== exp) begin
            $display("FAILED %s op2_dir: got %h expected %h at %0t", tag, got, exp, $time);
            value_errors++;
        end
    endtask

    task automatic check_reg_src(input string tag, input reg_src_t got, input reg_src_t exp);
        if (got !== exp) begin
            $display("FAILED %s reg_in_dir: got %h expected %h at %0t", tag, got, exp, $time);
            value_errors++;
        end
    endtask

    task automatic check_pc_src(input string tag, input pc_src_t got, input pc_src_t exp);
        if (got !== exp) begin
            $display("FAILED %s pc_in_dir: got %h expected %h at %0t", tag, got, exp, $time);
            value_errors++;
        end
    endtask

    // Sampled at the falling edge, outputs settled
    task automatic compare_outputs(input ctrl_state_t phase, input instr_t w_in);
        ctrl_word_t e;
        string      tag;
        e   = expected_ctrl(phase, w_in);
        tag = phase.name();
        check_bit({tag, " ram_cs"}, ram_cs, e.ram_cs);
        check_bit({tag, " ram_we"}, ram_we, e.ram_we);
        check_bit({tag, " ram_oe"}, ram_oe, e.ram_oe);
        check_bit({tag, " pc_en"}, pc_en, e.pc_en);
        check_bit({tag, " pc_sign"}, pc_sign, e.pc_sign);
        check_bit({tag, " ir_en"}, ir_en, e.ir_en);
        check_bit({tag, " reg_en"}, reg_en, e.reg_en);
        check_bit({tag, " reg_we"}, reg_we, e.reg_we);
        check_bit({tag, " alu_en"}, alu_en, e.alu_en);
        check_pc_src(tag, pc_in_dir, e.pc_in_dir);
        check_reg_src(tag, reg_in_dir, e.reg_in_dir);
        check_alu_op(tag, alu_op, e.alu_op);
        check_op2(tag, op2_dir, e.op2_dir);
    endtask

    // Two cycles of reset, then the silent PREPARE cycle
    task automatic apply_reset();
        @(posedge clk);
        reset <= 1'b1;
        repeat (2) begin
            @(negedge clk);
            compare_outputs(PREPARE, '0);
            @(posedge clk);
        end
        reset <= 1'b0;
        @(negedge clk);
        compare_outputs(PREPARE, '0);
    endtask

    // Fetch strobe must arrive exactly gap cycles later
    task automatic fetch_after(input int gap);
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < FETCH_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            seen = ram_cs && pc_en;
        end
        if (!seen) begin
            $display("Timed out after %0d cycles waiting for an instruction fetch", cycles);
            timing_errors++;
        end else begin
            if (cycles != gap) begin
                $display("Fetch strobe came after %0d cycles instead of %0d", cycles, gap);
                timing_errors++;
            end
            compare_outputs(FETCH, '0);
        end
    endtask

    // Word goes on instr at the edge that opens LATCH
    task automatic run_instr(input instr_t w_in);
        @(posedge clk);
        instr <= w_in;
        @(negedge clk);
        compare_outputs(LATCH, w_in);
        @(negedge clk);
        compare_outputs(EXEC, w_in);
        @(negedge clk);
        compare_outputs(COMPLETE, w_in);
    endtask

    task automatic run_illegal(input instr_t w_in);
        @(posedge clk);
        instr <= w_in;
        @(negedge clk);
        compare_outputs(LATCH, w_in);
        for (int n = 0; n < TRAP_WINDOW; n++) begin
            @(negedge clk);
            if (ir_en || ram_cs || pc_en || alu_en || reg_en) begin
                $display("Strobe seen %0d cycles after an illegal word", n + 1);
                timing_errors++;
            end
            compare_outputs(TRAP, w_in);
        end
    endtask

    initial begin
        reset         = 1'b1;
        instr         = '0;
        seed          = 32'hc1c4a7b7;
        value_errors  = 0;
        timing_errors = 0;

        apply_reset();
        fetch_after(1);

        // Every kept form twice, fresh register fields each time
        for (int i = 0; i < 28; i++) begin
            rnd  = $random(seed);
            word = kept_form(i % 14, rnd);
            run_instr(word);
            fetch_after(1);
        end

        // Random stream, rhythm checked by fetch_after
        for (int i = 0; i < 60; i++) begin
            rnd  = $random(seed);
            idx  = $unsigned($random(seed)) % 14;
            word = kept_form(idx, rnd);
            run_instr(word);
            fetch_after(1);
        end

        // MUL traps, reset recovers
        rnd = $random(seed);
        run_illegal({7'b0000001, rnd[24:15], F3_ADD_SUB, rnd[11:7], OPC_OP});
        apply_reset();
        fetch_after(1);
        run_instr(kept_form(10, rnd));
        fetch_after(1);

        // SD traps as well
        rnd = $random(seed);
        run_illegal({rnd[31:15], 3'b011, rnd[11:7], 7'b0100011});
        apply_reset();
        fetch_after(1);
        run_instr(kept_form(13, rnd));
        fetch_after(1);

        $display("Errors: %0d value mismatches, %0d timing errors", value_errors, timing_errors);
        if (value_errors == 0 && timing_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: cpu_ctrl.f
rv_isa_pkg.sv
cpu_ctrl_pkg.sv
instr_decoder.sv
ctrl_sequencer.sv
ctrl_signal_gen.sv
cpu_ctrl.sv
tb_cpu_ctrl.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_cpu_ctrl -f cpu_ctrl.f -o sim_cpu_ctrl

./obj_dir/sim_cpu_ctrl | tee sim.log

if grep -q "Result: PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
